// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - source/decode_pkg.sv
  - source/decode_pipe_reg.sv
  - source/inst_match.sv
  - source/imm_field_gen.sv
  - source/ctrl_gen.sv
  - source/decode_stage.sv
  - target: test
    files:
      - dv/decode_stage_tb.sv

// ==== all.f ====
source/decode_pkg.sv
source/decode_pipe_reg.sv
source/inst_match.sv
source/imm_field_gen.sv
source/ctrl_gen.sv
source/decode_stage.sv
dv/decode_stage_tb.sv

// ==== dv/decode_stage_tb.sv ====
module decode_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 20;

    logic                    clock;
    logic                    rst_i;
    logic                    fetch_valid_i;
    decode_pkg::fetch_pkt_t  fetch_pkt_i;
    logic                    fetch_ready_o;
    logic                    rf_valid_o;
    decode_pkg::decode_pkt_t rf_pkt_o;
    logic                    rf_ready_i;
    logic                    branch_flush_i;
    logic                    icache_flush_o;

    int unsigned lcg_state = 75;
    int          errs;
    int          tests_passed;
    int          tests_failed;

    decode_stage u_dut (
        .clock          (clock),
        .rst_i          (rst_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_pkt_i    (fetch_pkt_i),
        .fetch_ready_o  (fetch_ready_o),
        .rf_valid_o     (rf_valid_o),
        .rf_pkt_o       (rf_pkt_o),
        .rf_ready_i     (rf_ready_i),
        .branch_flush_i (branch_flush_i),
        .icache_flush_o (icache_flush_o)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // word aligned pc from the lcg
    function automatic decode_pkg::word_t next_pc();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[31:2], 2'b00};
    endfunction

    function automatic decode_pkg::inst_t encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, decode_pkg::OPC_OP};
    endfunction

    function automatic decode_pkg::inst_t encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic decode_pkg::inst_t encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], decode_pkg::OPC_STORE};
    endfunction

    function automatic decode_pkg::inst_t encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], decode_pkg::OPC_BRANCH};
    endfunction

    function automatic decode_pkg::inst_t encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                                   input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic decode_pkg::inst_t encode_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, decode_pkg::OPC_JAL};
    endfunction

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s expected %0h actual %0h", test, field, expected, actual);
            errs++;
        end
    endtask

    task automatic report_test(input string test);
        if (errs == 0) begin
            tests_passed++;
            $display("%s: ok", test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test, errs);
        end
        errs = 0;
    endtask

    task automatic drive_fetch(input decode_pkg::word_t pc, input decode_pkg::inst_t inst);
        fetch_valid_i    = 1'b1;
        fetch_pkt_i.pc   = pc;
        fetch_pkt_i.snpc = pc + 32'd4;
        fetch_pkt_i.inst = inst;
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic send(input decode_pkg::word_t pc, input decode_pkg::inst_t inst);
        int   cycles;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        drive_fetch(pc, inst);
        while (!accepted && cycles < TIMEOUT_CYCLES) begin
            #1;
            accepted = fetch_ready_o;
            @(posedge clock);
            #1;
            cycles++;
        end
        fetch_valid_i = 1'b0;
        if (!accepted) begin
            $display("timeout: fetch_ready_o stayed low for %0d cycles", TIMEOUT_CYCLES);
            errs++;
        end
    endtask

    task automatic receive(output decode_pkg::decode_pkt_t pkt, output logic flush);
        int   cycles;
        logic seen;
        cycles     = 0;
        seen       = 1'b0;
        pkt        = '0;
        flush      = 1'b0;
        rf_ready_i = 1'b1;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            #1;
            if (rf_valid_o) begin
                seen  = 1'b1;
                pkt   = rf_pkt_o;
                flush = icache_flush_o;
            end
            @(posedge clock);
            #1;
            cycles++;
        end
        if (!seen) begin
            $display("timeout: rf_valid_o never went high in %0d cycles", TIMEOUT_CYCLES);
            errs++;
        end
    endtask

    task automatic decode_one(input decode_pkg::inst_t inst, output decode_pkg::word_t pc,
                              output decode_pkg::decode_pkt_t pkt);
        logic flush;
        pc = next_pc();
        send(pc, inst);
        receive(pkt, flush);
    endtask

    task automatic check_alu(input string test, input decode_pkg::inst_t inst,
                             input logic [2:0] alu, input logic [31:0] imm,
                             input logic src2_imm, input logic src1_pc, input logic [4:0] rd);
        decode_pkg::word_t       pc;
        decode_pkg::decode_pkt_t pkt;
        decode_one(inst, pc, pkt);
        check_field(test, "alu_op", alu, pkt.ctrl.alu_op);
        check_field(test, "imm", imm, pkt.imm);
        check_field(test, "src2_is_imm", src2_imm, pkt.ctrl.src2_is_imm);
        check_field(test, "gr_we", 1'b1, pkt.ctrl.gr_we);
        check_field(test, "src1", src1_pc ? pc : 32'd0, pkt.src1);
        check_field(test, "rd", rd, pkt.rd);
    endtask

    task automatic check_mem(input string test, input decode_pkg::inst_t inst,
                             input logic [3:0] re, input logic [3:0] we,
                             input logic [31:0] imm, input logic gr_we,
                             input logic [4:0] rs1);
        decode_pkg::word_t       pc;
        decode_pkg::decode_pkt_t pkt;
        decode_one(inst, pc, pkt);
        check_field(test, "mem_re", re, pkt.ctrl.mem_re);
        check_field(test, "mem_we", we, pkt.ctrl.mem_we);
        check_field(test, "imm", imm, pkt.imm);
        check_field(test, "gr_we", gr_we, pkt.ctrl.gr_we);
        check_field(test, "rs1", rs1, pkt.rs1);
        check_field(test, "res_from_mem", re != 4'b0000, pkt.ctrl.res_from_mem);
    endtask

    task automatic check_misc(input string test, input decode_pkg::inst_t inst,
                              input logic [2:0] cmp, input logic br, input logic slt,
                              input logic csr_we, input logic src2_csr, input logic excp,
                              input logic xret, input logic [31:0] imm, input logic gr_we);
        decode_pkg::word_t       pc;
        decode_pkg::decode_pkt_t pkt;
        decode_one(inst, pc, pkt);
        check_field(test, "cmp_fn", cmp, pkt.ctrl.cmp_fn);
        check_field(test, "br", br, pkt.ctrl.br);
        check_field(test, "res_from_cmp", slt, pkt.ctrl.res_from_cmp);
        check_field(test, "csr_we", csr_we, pkt.ctrl.csr_we);
        check_field(test, "src2_is_csr", src2_csr, pkt.ctrl.src2_is_csr);
        check_field(test, "excp_flush", excp, pkt.ctrl.excp_flush);
        check_field(test, "xret_flush", xret, pkt.ctrl.xret_flush);
        check_field(test, "imm", imm, pkt.imm);
        check_field(test, "gr_we", gr_we, pkt.ctrl.gr_we);
    endtask

    task automatic test_reset();
        #1;
        check_field("reset", "rf_valid_o", 1'b0, rf_valid_o);
        check_field("reset", "icache_flush_o", 1'b0, icache_flush_o);
        check_field("reset", "fetch_ready_o", 1'b1, fetch_ready_o);
        @(posedge clock);
        #1;
        report_test("reset");
    endtask

    task automatic test_alu_ops();
        check_alu("alu_ops/add", encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3),
                  decode_pkg::ALU_ADD, 32'h0, 1'b0, 1'b0, 5'd3);
        check_alu("alu_ops/sub", encode_r(7'h20, 5'd7, 5'd6, 3'b000, 5'd5),
                  decode_pkg::ALU_SUB, 32'h0, 1'b0, 1'b0, 5'd5);
        check_alu("alu_ops/xori", encode_i(12'hFFB, 5'd9, 3'b100, 5'd8, decode_pkg::OPC_OP_IMM),
                  decode_pkg::ALU_XOR, 32'hFFFF_FFFB, 1'b1, 1'b0, 5'd8);
        // shamt 7 with funct7 0100000 in the upper bits
        check_alu("alu_ops/srai", encode_i(12'h407, 5'd11, 3'b101, 5'd10, decode_pkg::OPC_OP_IMM),
                  decode_pkg::ALU_SRA, 32'h0000_0407, 1'b1, 1'b0, 5'd10);
        check_alu("alu_ops/lui", encode_u(20'hABCDE, 5'd12, decode_pkg::OPC_LUI),
                  decode_pkg::ALU_ADD, 32'hABCD_E000, 1'b1, 1'b0, 5'd12);
        check_alu("alu_ops/auipc", encode_u(20'h12345, 5'd13, decode_pkg::OPC_AUIPC),
                  decode_pkg::ALU_ADD, 32'h1234_5000, 1'b1, 1'b1, 5'd13);
        check_alu("alu_ops/jal", encode_j(21'h1F_F800, 5'd1),
                  decode_pkg::ALU_ADD, 32'hFFFF_F800, 1'b1, 1'b1, 5'd1);
        report_test("alu_ops");
    endtask

    task automatic test_load_store();
        check_mem("load_store/lb", encode_i(12'hFFF, 5'd2, 3'b000, 5'd4, decode_pkg::OPC_LOAD),
                  4'b0101, 4'b0000, 32'hFFFF_FFFF, 1'b1, 5'd2);
        check_mem("load_store/lhu", encode_i(12'h7FF, 5'd2, 3'b101, 5'd4, decode_pkg::OPC_LOAD),
                  4'b0011, 4'b0000, 32'h0000_07FF, 1'b1, 5'd2);
        check_mem("load_store/lw", encode_i(12'h800, 5'd3, 3'b010, 5'd6, decode_pkg::OPC_LOAD),
                  4'b1111, 4'b0000, 32'hFFFF_F800, 1'b1, 5'd3);
        check_mem("load_store/sb", encode_s(12'hFFD, 5'd5, 5'd2, 3'b000),
                  4'b0000, 4'b0001, 32'hFFFF_FFFD, 1'b0, 5'd2);
        check_mem("load_store/sh", encode_s(12'h123, 5'd5, 5'd2, 3'b001),
                  4'b0000, 4'b0011, 32'h0000_0123, 1'b0, 5'd2);
        check_mem("load_store/sw", encode_s(12'hF00, 5'd7, 5'd8, 3'b010),
                  4'b0000, 4'b1111, 32'hFFFF_FF00, 1'b0, 5'd8);
        report_test("load_store");
    endtask

    task automatic test_branch_csr_priv();
        decode_pkg::word_t       pc;
        decode_pkg::decode_pkt_t pkt;
        check_misc("branch_csr_priv/beq", encode_b(13'h1FF0, 5'd2, 5'd1, 3'b000),
                   decode_pkg::CMP_EQ, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'hFFFF_FFF0, 1'b0);
        // offset with bit 11 set, which sits in inst[7]
        check_misc("branch_csr_priv/bgeu", encode_b(13'h0804, 5'd4, 5'd3, 3'b111),
                   decode_pkg::CMP_GEU, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0000_0804, 1'b0);
        check_misc("branch_csr_priv/sltiu",
                   encode_i(12'hFFF, 5'd6, 3'b011, 5'd5, decode_pkg::OPC_OP_IMM),
                   decode_pkg::CMP_LTU, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'hFFFF_FFFF, 1'b1);
        check_misc("branch_csr_priv/csrrs",
                   encode_i(12'h300, 5'd0, 3'b010, 5'd7, decode_pkg::OPC_SYSTEM),
                   3'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0, 1'b1);
        check_misc("branch_csr_priv/ecall", 32'h0000_0073,
                   3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0);
        check_misc("branch_csr_priv/mret", 32'h3020_0073,
                   3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
        // csr address and source register fields
        decode_one(encode_i(12'h305, 5'd3, 3'b001, 5'd0, decode_pkg::OPC_SYSTEM), pc, pkt);
        check_field("branch_csr_priv/csrrw", "csr_addr", 32'h305, pkt.csr_addr);
        check_field("branch_csr_priv/csrrw", "rs1", 5'd3, pkt.rs1);
        check_field("branch_csr_priv/csrrw", "csr_we", 1'b1, pkt.ctrl.csr_we);
        check_field("branch_csr_priv/csrrw", "src2_is_csr", 1'b0, pkt.ctrl.src2_is_csr);
        report_test("branch_csr_priv");
    endtask

    task automatic test_back_pressure();
        decode_pkg::word_t       pc_a;
        decode_pkg::word_t       pc_b;
        decode_pkg::decode_pkt_t pkt;
        logic                    flush;
        pc_a       = next_pc();
        pc_b       = next_pc();
        rf_ready_i = 1'b0;
        send(pc_a, encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        // second item waits at the input
        drive_fetch(pc_b, encode_i(12'h010, 5'd4, 3'b000, 5'd9, decode_pkg::OPC_OP_IMM));
        repeat (3) begin
            #1;
            check_field("back_pressure", "fetch_ready_o", 1'b0, fetch_ready_o);
            check_field("back_pressure", "rf_valid_o", 1'b1, rf_valid_o);
            check_field("back_pressure", "held pc", pc_a, rf_pkt_o.pc);
            check_field("back_pressure", "held rd", 5'd3, rf_pkt_o.rd);
            @(posedge clock);
            #1;
        end
        receive(pkt, flush);
        fetch_valid_i = 1'b0;
        check_field("back_pressure", "first pc", pc_a, pkt.pc);
        check_field("back_pressure", "first rs1", 5'd1, pkt.rs1);
        check_field("back_pressure", "first rs2", 5'd2, pkt.rs2);
        receive(pkt, flush);
        check_field("back_pressure", "second pc", pc_b, pkt.pc);
        check_field("back_pressure", "second snpc", pc_b + 32'd4, pkt.snpc);
        check_field("back_pressure", "second imm", 32'h10, pkt.imm);
        report_test("back_pressure");
    endtask

    task automatic test_flush_fence();
        decode_pkg::word_t       pc_f;
        decode_pkg::decode_pkt_t pkt;
        logic                    flush;
        rf_ready_i = 1'b0;
        send(next_pc(), encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        branch_flush_i = 1'b1;
        #1;
        check_field("flush_fence", "rf_valid_o in flush", 1'b0, rf_valid_o);
        @(posedge clock);
        #1;
        branch_flush_i = 1'b0;
        rf_ready_i     = 1'b1;
        repeat (3) begin
            #1;
            check_field("flush_fence", "rf_valid_o after flush", 1'b0, rf_valid_o);
            @(posedge clock);
            #1;
        end
        pc_f       = next_pc();
        rf_ready_i = 1'b0;
        send(pc_f, encode_i(12'h000, 5'd0, 3'b001, 5'd0, decode_pkg::OPC_MISC_MEM));
        #1;
        check_field("flush_fence", "held fence.i valid", 1'b1, rf_valid_o);
        check_field("flush_fence", "icache_flush_o while held", 1'b0, icache_flush_o);
        @(posedge clock);
        #1;
        receive(pkt, flush);
        check_field("flush_fence", "fence.i pc", pc_f, pkt.pc);
        check_field("flush_fence", "icache_flush_o on transfer", 1'b1, flush);
        #1;
        check_field("flush_fence", "icache_flush_o after", 1'b0, icache_flush_o);
        @(posedge clock);
        #1;
        report_test("flush_fence");
    endtask

    initial begin
        rst_i          = 1'b1;
        fetch_valid_i  = 1'b0;
        fetch_pkt_i    = '0;
        rf_ready_i     = 1'b1;
        branch_flush_i = 1'b0;
        errs           = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        repeat (8) @(posedge clock);
        #1;
        rst_i = 1'b0;

        test_reset();
        test_alu_ops();
        test_load_store();
        test_branch_csr_priv();
        test_back_pressure();
        test_flush_fence();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== source/ctrl_gen.sv ====
module ctrl_gen (
    input  decode_pkg::inst_flags_t flags_i,
    input  decode_pkg::optype_t     optype_i,
    input  decode_pkg::word_t       pc_i,
    output decode_pkg::ctrl_t       ctrl_o,
    output decode_pkg::word_t       src1_o
);

    logic src1_is_pc;
    logic is_load;
    logic is_branch;
    logic is_slt;
    logic is_trap;

    assign is_load   = flags_i.lb || flags_i.lh || flags_i.lw || flags_i.lbu || flags_i.lhu;
    assign is_branch = flags_i.beq || flags_i.bne || flags_i.blt || flags_i.bge ||
                       flags_i.bltu || flags_i.bgeu;
    assign is_slt    = flags_i.slt || flags_i.sltu || flags_i.slti || flags_i.sltiu;
    assign is_trap   = flags_i.ecall || flags_i.ebreak || flags_i.mret;

    // add is the default, covering addresses, lui, auipc and links
    assign ctrl_o.alu_op =
        ({3{flags_i.sub}}                    & decode_pkg::ALU_SUB) |
        ({3{flags_i.sll || flags_i.slli}}    & decode_pkg::ALU_SLL) |
        ({3{flags_i.sra || flags_i.srai}}    & decode_pkg::ALU_SRA) |
        ({3{flags_i.srl || flags_i.srli}}    & decode_pkg::ALU_SRL) |
        ({3{flags_i.and_r || flags_i.andi}}  & decode_pkg::ALU_AND) |
        ({3{flags_i.or_r || flags_i.ori}}    & decode_pkg::ALU_OR)  |
        ({3{flags_i.xor_r || flags_i.xori}}  & decode_pkg::ALU_XOR);

    assign ctrl_o.cmp_fn =
        ({3{flags_i.beq}}  & decode_pkg::CMP_EQ) |
        ({3{flags_i.bne}}  & decode_pkg::CMP_NE) |
        ({3{flags_i.bge}}  & decode_pkg::CMP_GE) |
        ({3{flags_i.blt || flags_i.slt || flags_i.slti}}     & decode_pkg::CMP_LT)  |
        ({3{flags_i.bltu || flags_i.sltu || flags_i.sltiu}}  & decode_pkg::CMP_LTU) |
        ({3{flags_i.bgeu}} & decode_pkg::CMP_GEU);

    assign ctrl_o.cmp_src2_is_imm = flags_i.slti || flags_i.sltiu;
    assign ctrl_o.src2_is_imm     = optype_i == decode_pkg::OPT_I ||
                                    optype_i == decode_pkg::OPT_S ||
                                    optype_i == decode_pkg::OPT_B ||
                                    optype_i == decode_pkg::OPT_U ||
                                    optype_i == decode_pkg::OPT_J;
    assign ctrl_o.src2_is_csr     = flags_i.csrrs;
    assign ctrl_o.csr_op          = flags_i.csrrw;
    assign ctrl_o.res_from_cmp    = is_slt;

    assign src1_is_pc = optype_i == decode_pkg::OPT_J || optype_i == decode_pkg::OPT_B ||
                        flags_i.auipc;
    // lui takes its zero src1 from here as well
    assign ctrl_o.src1_from_pre = src1_is_pc || flags_i.lui;
    assign src1_o               = src1_is_pc ? pc_i : '0;

    assign ctrl_o.res_from_mem = is_load;
    assign ctrl_o.res_from_csr = flags_i.csrrw || flags_i.csrrs;
    assign ctrl_o.xret_flush   = flags_i.mret;
    assign ctrl_o.break_sig    = flags_i.ebreak;
    assign ctrl_o.excp_flush   = flags_i.ecall;

    // no rd for stores, branches, traps, fence.i or unknown opcodes
    assign ctrl_o.gr_we = optype_i != decode_pkg::OPT_NONE &&
                          optype_i != decode_pkg::OPT_S &&
                          optype_i != decode_pkg::OPT_B && !is_trap;
    assign ctrl_o.csr_we = flags_i.csrrw || flags_i.csrrs;

    assign ctrl_o.mem_re = ({4{flags_i.lb}}  & decode_pkg::MEM_LB)  |
                           ({4{flags_i.lh}}  & decode_pkg::MEM_LH)  |
                           ({4{flags_i.lw}}  & decode_pkg::MEM_LW)  |
                           ({4{flags_i.lbu}} & decode_pkg::MEM_LBU) |
                           ({4{flags_i.lhu}} & decode_pkg::MEM_LHU);

    assign ctrl_o.mem_we = ({4{flags_i.sb}} & decode_pkg::MEM_SB) |
                           ({4{flags_i.sh}} & decode_pkg::MEM_SH) |
                           ({4{flags_i.sw}} & decode_pkg::MEM_SW);

    assign ctrl_o.jmp = flags_i.jal || flags_i.jalr;
    assign ctrl_o.br  = is_branch;

endmodule

// ==== source/decode_pipe_reg.sv ====
module decode_pipe_reg (
    input  logic                   clock,
    input  logic                   rst_i,
    input  logic                   in_valid_i,
    input  decode_pkg::fetch_pkt_t in_pkt_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    output decode_pkg::fetch_pkt_t out_pkt_o,
    input  logic                   out_ready_i,
    input  logic                   flush_i
);

    logic                   valid_q;
    decode_pkg::fetch_pkt_t pkt_q;
    logic                   in_fire;
    logic                   out_fire;

    assign in_fire  = in_valid_i && in_ready_o;
    assign out_fire = out_valid_o && out_ready_i;

    always_ff @(posedge clock) begin
        if (in_fire) begin
            pkt_q <= in_pkt_i;
        end
    end

    // flush wins over a load in the same cycle
    always_ff @(posedge clock) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_fire) begin
            valid_q <= 1'b0;
        end
    end

    assign out_valid_o = valid_q && !flush_i;
    assign out_pkt_o   = pkt_q;

    // empty, or the held item leaves this cycle
    assign in_ready_o = !valid_q || out_fire;

endmodule

// ==== source/decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // instruction format class
    typedef logic [2:0] optype_t;
    localparam optype_t OPT_NONE = 3'd0;
    localparam optype_t OPT_R    = 3'd1;
    localparam optype_t OPT_I    = 3'd2;
    localparam optype_t OPT_S    = 3'd3;
    localparam optype_t OPT_B    = 3'd4;
    localparam optype_t OPT_U    = 3'd5;
    localparam optype_t OPT_J    = 3'd6;
    localparam optype_t OPT_PRIV = 3'd7;

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_SLL = 3'd2;
    localparam alu_op_t ALU_SRA = 3'd3;
    localparam alu_op_t ALU_SRL = 3'd4;
    localparam alu_op_t ALU_AND = 3'd5;
    localparam alu_op_t ALU_OR  = 3'd6;
    localparam alu_op_t ALU_XOR = 3'd7;

    typedef logic [2:0] cmp_fn_t;
    localparam cmp_fn_t CMP_EQ  = 3'd0;
    localparam cmp_fn_t CMP_NE  = 3'd1;
    localparam cmp_fn_t CMP_GE  = 3'd2;
    localparam cmp_fn_t CMP_LT  = 3'd3;
    localparam cmp_fn_t CMP_LTU = 3'd5;
    localparam cmp_fn_t CMP_GEU = 3'd6;

    // byte lanes; bit 2 on loads marks sign extension
    typedef logic [3:0] mem_mask_t;
    localparam mem_mask_t MEM_LB  = 4'b0101;
    localparam mem_mask_t MEM_LH  = 4'b0111;
    localparam mem_mask_t MEM_LW  = 4'b1111;
    localparam mem_mask_t MEM_LBU = 4'b0001;
    localparam mem_mask_t MEM_LHU = 4'b0011;
    localparam mem_mask_t MEM_SB  = 4'b0001;
    localparam mem_mask_t MEM_SH  = 4'b0011;
    localparam mem_mask_t MEM_SW  = 4'b1111;

    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;
    localparam funct7_t F7_MRET = 7'b0011000;

    typedef struct packed {
        word_t pc;
        word_t snpc;
        inst_t inst;
    } fetch_pkt_t;

    // xor_r, or_r, and_r are the register forms
    typedef struct packed {
        logic lui, auipc, jal, jalr;
        logic lb, lh, lw, lbu, lhu;
        logic sb, sh, sw;
        logic addi, xori, ori, andi, slli, srli, srai;
        logic add, sub, sll, xor_r, srl, sra, or_r, and_r;
        logic beq, bne, blt, bge, bltu, bgeu;
        logic slti, sltiu, slt, sltu;
        logic ecall, ebreak, mret;
        logic csrrw, csrrs;
        logic fence_i;
    } inst_flags_t;

    typedef struct packed {
        alu_op_t   alu_op;
        cmp_fn_t   cmp_fn;
        logic      cmp_src2_is_imm;
        logic      src2_is_imm;
        logic      src2_is_csr;
        logic      csr_op;
        logic      res_from_cmp;
        logic      src1_from_pre;
        logic      res_from_mem;
        logic      res_from_csr;
        logic      xret_flush;
        logic      break_sig;
        logic      excp_flush;
        logic      gr_we;
        logic      csr_we;
        mem_mask_t mem_re;
        mem_mask_t mem_we;
        logic      jmp;
        logic      br;
    } ctrl_t;

    typedef struct packed {
        word_t     pc;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        csr_addr_t csr_addr;
        word_t     imm;
        word_t     src1;
        word_t     snpc;
        ctrl_t     ctrl;
    } decode_pkt_t;

endpackage

// ==== source/decode_stage.sv ====
module decode_stage (
    input  logic                    clock,
    input  logic                    rst_i,
    input  logic                    fetch_valid_i,
    input  decode_pkg::fetch_pkt_t  fetch_pkt_i,
    output logic                    fetch_ready_o,
    output logic                    rf_valid_o,
    output decode_pkg::decode_pkt_t rf_pkt_o,
    input  logic                    rf_ready_i,
    input  logic                    branch_flush_i,
    output logic                    icache_flush_o
);

    decode_pkg::fetch_pkt_t  held_pkt;
    decode_pkg::inst_flags_t flags;
    decode_pkg::optype_t     optype;

    decode_pipe_reg u_pipe_reg (
        .clock       (clock),
        .rst_i       (rst_i),
        .in_valid_i  (fetch_valid_i),
        .in_pkt_i    (fetch_pkt_i),
        .in_ready_o  (fetch_ready_o),
        .out_valid_o (rf_valid_o),
        .out_pkt_o   (held_pkt),
        .out_ready_i (rf_ready_i),
        .flush_i     (branch_flush_i)
    );

    inst_match u_inst_match (
        .inst_i   (held_pkt.inst),
        .flags_o  (flags),
        .optype_o (optype)
    );

    imm_field_gen u_imm_field_gen (
        .inst_i     (held_pkt.inst),
        .optype_i   (optype),
        .rs1_o      (rf_pkt_o.rs1),
        .rs2_o      (rf_pkt_o.rs2),
        .rd_o       (rf_pkt_o.rd),
        .csr_addr_o (rf_pkt_o.csr_addr),
        .imm_o      (rf_pkt_o.imm)
    );

    ctrl_gen u_ctrl_gen (
        .flags_i  (flags),
        .optype_i (optype),
        .pc_i     (held_pkt.pc),
        .ctrl_o   (rf_pkt_o.ctrl),
        .src1_o   (rf_pkt_o.src1)
    );

    assign rf_pkt_o.pc   = held_pkt.pc;
    assign rf_pkt_o.snpc = held_pkt.snpc;

    // only when the fence.i actually leaves the stage
    assign icache_flush_o = rf_valid_o && rf_ready_i && flags.fence_i;

endmodule

// ==== source/imm_field_gen.sv ====
module imm_field_gen (
    input  decode_pkg::inst_t     inst_i,
    input  decode_pkg::optype_t   optype_i,
    output decode_pkg::reg_idx_t  rs1_o,
    output decode_pkg::reg_idx_t  rs2_o,
    output decode_pkg::reg_idx_t  rd_o,
    output decode_pkg::csr_addr_t csr_addr_o,
    output decode_pkg::word_t     imm_o
);

    decode_pkg::word_t imm_i;
    decode_pkg::word_t imm_s;
    decode_pkg::word_t imm_b;
    decode_pkg::word_t imm_u;
    decode_pkg::word_t imm_j;

    assign rs1_o      = inst_i[19:15];
    assign rs2_o      = inst_i[24:20];
    assign rd_o       = inst_i[11:7];
    assign csr_addr_o = inst_i[31:20];

    // all sign bits come from inst[31]
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        case (optype_i)
            decode_pkg::OPT_I: imm_o = imm_i;
            decode_pkg::OPT_S: imm_o = imm_s;
            decode_pkg::OPT_B: imm_o = imm_b;
            decode_pkg::OPT_U: imm_o = imm_u;
            decode_pkg::OPT_J: imm_o = imm_j;
            // R, PRIV and unknown carry no immediate
            default:           imm_o = '0;
        endcase
    end

endmodule

// ==== source/inst_match.sv ====
module inst_match (
    input  decode_pkg::inst_t       inst_i,
    output decode_pkg::inst_flags_t flags_o,
    output decode_pkg::optype_t     optype_o
);

    decode_pkg::opcode_t  opcode;
    decode_pkg::funct3_t  funct3;
    decode_pkg::funct7_t  funct7;
    decode_pkg::reg_idx_t rd;
    decode_pkg::reg_idx_t rs1;
    decode_pkg::reg_idx_t rs2;
    logic                 is_op;
    logic                 is_op_imm;
    logic                 is_load;
    logic                 is_store;
    logic                 is_branch;
    logic                 is_system;
    logic                 f7_base;
    logic                 f7_alt;
    logic                 priv_base;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign is_op     = opcode == decode_pkg::OPC_OP;
    assign is_op_imm = opcode == decode_pkg::OPC_OP_IMM;
    assign is_load   = opcode == decode_pkg::OPC_LOAD;
    assign is_store  = opcode == decode_pkg::OPC_STORE;
    assign is_branch = opcode == decode_pkg::OPC_BRANCH;
    assign is_system = opcode == decode_pkg::OPC_SYSTEM;
    assign f7_base   = funct7 == decode_pkg::F7_BASE;
    assign f7_alt    = funct7 == decode_pkg::F7_ALT;

    // common part of ecall/ebreak/mret
    assign priv_base = is_system && funct3 == 3'b000 && rd == 5'd0 && rs1 == 5'd0;

    assign flags_o.lui   = opcode == decode_pkg::OPC_LUI;
    assign flags_o.auipc = opcode == decode_pkg::OPC_AUIPC;
    assign flags_o.jal   = opcode == decode_pkg::OPC_JAL;
    assign flags_o.jalr  = opcode == decode_pkg::OPC_JALR && funct3 == 3'b000;

    assign flags_o.lb  = is_load && funct3 == 3'b000;
    assign flags_o.lh  = is_load && funct3 == 3'b001;
    assign flags_o.lw  = is_load && funct3 == 3'b010;
    assign flags_o.lbu = is_load && funct3 == 3'b100;
    assign flags_o.lhu = is_load && funct3 == 3'b101;
    assign flags_o.sb  = is_store && funct3 == 3'b000;
    assign flags_o.sh  = is_store && funct3 == 3'b001;
    assign flags_o.sw  = is_store && funct3 == 3'b010;

    assign flags_o.addi  = is_op_imm && funct3 == 3'b000;
    assign flags_o.slti  = is_op_imm && funct3 == 3'b010;
    assign flags_o.sltiu = is_op_imm && funct3 == 3'b011;
    assign flags_o.xori  = is_op_imm && funct3 == 3'b100;
    assign flags_o.ori   = is_op_imm && funct3 == 3'b110;
    assign flags_o.andi  = is_op_imm && funct3 == 3'b111;
    assign flags_o.slli  = is_op_imm && funct3 == 3'b001 && f7_base;
    assign flags_o.srli  = is_op_imm && funct3 == 3'b101 && f7_base;
    assign flags_o.srai  = is_op_imm && funct3 == 3'b101 && f7_alt;

    assign flags_o.add   = is_op && funct3 == 3'b000 && f7_base;
    assign flags_o.sub   = is_op && funct3 == 3'b000 && f7_alt;
    assign flags_o.sll   = is_op && funct3 == 3'b001 && f7_base;
    assign flags_o.slt   = is_op && funct3 == 3'b010 && f7_base;
    assign flags_o.sltu  = is_op && funct3 == 3'b011 && f7_base;
    assign flags_o.xor_r = is_op && funct3 == 3'b100 && f7_base;
    assign flags_o.srl   = is_op && funct3 == 3'b101 && f7_base;
    assign flags_o.sra   = is_op && funct3 == 3'b101 && f7_alt;
    assign flags_o.or_r  = is_op && funct3 == 3'b110 && f7_base;
    assign flags_o.and_r = is_op && funct3 == 3'b111 && f7_base;

    assign flags_o.beq  = is_branch && funct3 == 3'b000;
    assign flags_o.bne  = is_branch && funct3 == 3'b001;
    assign flags_o.blt  = is_branch && funct3 == 3'b100;
    assign flags_o.bge  = is_branch && funct3 == 3'b101;
    assign flags_o.bltu = is_branch && funct3 == 3'b110;
    assign flags_o.bgeu = is_branch && funct3 == 3'b111;

    assign flags_o.ecall  = priv_base && f7_base && rs2 == 5'd0;
    assign flags_o.ebreak = priv_base && f7_base && rs2 == 5'd1;
    assign flags_o.mret   = priv_base && funct7 == decode_pkg::F7_MRET && rs2 == 5'd2;
    assign flags_o.csrrw  = is_system && funct3 == 3'b001;
    assign flags_o.csrrs  = is_system && funct3 == 3'b010;

    assign flags_o.fence_i = opcode == decode_pkg::OPC_MISC_MEM && funct3 == 3'b001;

    always_comb begin
        case (opcode)
            decode_pkg::OPC_OP:       optype_o = decode_pkg::OPT_R;
            decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_LOAD,
            decode_pkg::OPC_JALR:     optype_o = decode_pkg::OPT_I;
            decode_pkg::OPC_STORE:    optype_o = decode_pkg::OPT_S;
            decode_pkg::OPC_BRANCH:   optype_o = decode_pkg::OPT_B;
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC:    optype_o = decode_pkg::OPT_U;
            decode_pkg::OPC_JAL:      optype_o = decode_pkg::OPT_J;
            decode_pkg::OPC_SYSTEM:   optype_o = decode_pkg::OPT_PRIV;
            default:                  optype_o = decode_pkg::OPT_NONE;
        endcase
    end

endmodule
